// ==== verilog/mist_pkg.sv ====
package mist_pkg;

    // one byte of the downloaded game image
    typedef logic [7:0] byte_t;

    // a single colour channel at the video output
    typedef logic [3:0] color_t;

    // vertical phase of the frame
    //   st_active  lines carrying picture
    //   st_front   one line of front porch
    //   st_sync    two lines with vs high
    //   st_back    remaining lines up to V_TOTAL
    typedef enum logic [1:0] {
        st_active = 2'd0,
        st_front  = 2'd1,
        st_sync   = 2'd2,
        st_back   = 2'd3
    } vid_state_t;

endpackage

// ==== verilog/ioctl_if.sv ====
`timescale 1ns/1ns

interface ioctl_if #(
    parameter int ROM_AW = 10
);

    logic [ROM_AW-1:0] addr;
    mist_pkg::byte_t   data;
    // one-cycle write strobe
    logic              wr;
    // high for the whole download frame
    logic              downloading;

    modport driver (
        output addr,
        output data,
        output wr,
        output downloading
    );

    modport receiver (
        input addr,
        input data,
        input wr
    );

    modport monitor (
        input downloading
    );

endinterface

// ==== verilog/video_if.sv ====
`timescale 1ns/1ns

interface video_if #(
    parameter int H_TOTAL = 24,
    parameter int V_TOTAL = 12
);

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    logic          pxl_cen;
    logic [HW-1:0] hcnt;
    logic [VW-1:0] vcnt;
    // flags decoded from the current counters
    logic          hblank;
    logic          vblank;
    logic          hs;
    logic          vs;

    modport source (
        output pxl_cen,
        output hcnt,
        output vcnt,
        output hblank,
        output vblank,
        output hs,
        output vs
    );

    modport sink (
        input pxl_cen,
        input hcnt,
        input vcnt,
        input hblank,
        input vblank,
        input hs,
        input vs
    );

endinterface

// ==== verilog/spi_download.sv ====
`timescale 1ns/1ns

module spi_download (
    input  logic    clk,
    input  logic    reset,
    input  logic    spi_sck,
    input  logic    spi_ss2,
    input  logic    spi_di,
    ioctl_if.driver ioctl
);

    logic [1:0] sck_sync;
    logic [1:0] ss_sync;
    logic [1:0] di_sync;
    logic       sck_last;
    logic [2:0] bit_cnt;
    logic [6:0] shift;
    logic       sck_rise;
    logic       frame_start;

    assign sck_rise    = sck_sync[1] & ~sck_last;
    // ss2 seen low while not yet downloading
    assign frame_start = ~ss_sync[1] & ~ioctl.downloading;

    always_ff @(posedge clk) begin
        if (reset) begin
            sck_sync          <= 2'b00;
            ss_sync           <= 2'b11;
            sck_last          <= 1'b0;
            bit_cnt           <= 3'd0;
            ioctl.downloading <= 1'b0;
            ioctl.wr          <= 1'b0;
            ioctl.addr        <= '0;
        end else begin
            sck_sync          <= {sck_sync[0], spi_sck};
            ss_sync           <= {ss_sync[0], spi_ss2};
            sck_last          <= sck_sync[1];
            ioctl.downloading <= ~ss_sync[1];
            ioctl.wr          <= 1'b0;
            // step past the byte just written, wraps at the ROM size
            if (ioctl.wr) begin
                ioctl.addr <= ioctl.addr + 1'b1;
            end
            if (frame_start) begin
                ioctl.addr <= '0;
                bit_cnt    <= 3'd0;
            end else if (sck_rise && !ss_sync[1]) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    ioctl.wr <= 1'b1;
                end
            end
        end
    end

    // serial data path, MSB first
    always_ff @(posedge clk) begin
        di_sync <= {di_sync[0], spi_di};
        if (sck_rise) begin
            shift <= {shift[5:0], di_sync[1]};
            if (bit_cnt == 3'd7) begin
                ioctl.data <= {shift, di_sync[1]};
            end
        end
    end

    // a partial byte at frame end never reaches the ROM
    a_wr_in_frame: assert property (
        @(posedge clk) disable iff (reset) ioctl.wr |-> ioctl.downloading
    ) else $error("spi_download: write strobe outside a download frame");

endmodule

// ==== verilog/rom_buffer.sv ====
`timescale 1ns/1ns

module rom_buffer #(
    parameter int ROM_AW = 10
) (
    input  logic              clk,
    ioctl_if.receiver         ioctl,
    input  logic [ROM_AW-1:0] rd_addr,
    output mist_pkg::byte_t   rd_data
);

    localparam int DEPTH = 1 << ROM_AW;

    mist_pkg::byte_t mem [0:DEPTH-1];

    // download port
    always_ff @(posedge clk) begin
        if (ioctl.wr) begin
            mem[ioctl.addr] <= ioctl.data;
        end
    end

    // video port, one clock of latency
    // a read colliding with a write returns the old byte
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== verilog/video_timing.sv ====
`timescale 1ns/1ns

module video_timing #(
    parameter int H_VISIBLE = 16,
    parameter int H_TOTAL   = 24,
    parameter int V_VISIBLE = 8,
    parameter int V_TOTAL   = 12,
    parameter int CEN_DIV   = 2
) (
    input  logic     clk,
    input  logic     reset,
    video_if.source  video
);

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);
    localparam int CW = $clog2(CEN_DIV);

    logic [CW-1:0]        cen_cnt;
    logic                 pxl_cen;
    logic [HW-1:0]        hcnt;
    logic [VW-1:0]        vcnt;
    logic                 line_end;
    mist_pkg::vid_state_t state;
    mist_pkg::vid_state_t state_next;

    // pixel enable, one clock in CEN_DIV
    always_ff @(posedge clk) begin
        if (reset) begin
            cen_cnt <= '0;
            pxl_cen <= 1'b0;
        end else if (cen_cnt == CW'(CEN_DIV - 1)) begin
            cen_cnt <= '0;
            pxl_cen <= 1'b1;
        end else begin
            cen_cnt <= cen_cnt + 1'b1;
            pxl_cen <= 1'b0;
        end
    end

    assign line_end = hcnt == HW'(H_TOTAL - 1);

    always_comb begin
        state_next = state;
        case (state)
            mist_pkg::st_active:
                if (vcnt == VW'(V_VISIBLE - 1)) state_next = mist_pkg::st_front;
            mist_pkg::st_front:
                state_next = mist_pkg::st_sync;
            mist_pkg::st_sync:
                if (vcnt == VW'(V_VISIBLE + 2)) begin
                    // back porch may be empty
                    state_next = (vcnt == VW'(V_TOTAL - 1)) ? mist_pkg::st_active
                                                             : mist_pkg::st_back;
                end
            default:
                if (vcnt == VW'(V_TOTAL - 1)) state_next = mist_pkg::st_active;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hcnt  <= '0;
            vcnt  <= '0;
            state <= mist_pkg::st_active;
        end else if (pxl_cen) begin
            if (line_end) begin
                hcnt  <= '0;
                vcnt  <= (vcnt == VW'(V_TOTAL - 1)) ? '0 : vcnt + 1'b1;
                state <= state_next;
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    assign video.pxl_cen = pxl_cen;
    assign video.hcnt    = hcnt;
    assign video.vcnt    = vcnt;
    assign video.hblank  = hcnt >= HW'(H_VISIBLE);
    // four pixels of sync after one pixel of front porch
    assign video.hs      = hcnt >= HW'(H_VISIBLE + 1) && hcnt <= HW'(H_VISIBLE + 4);
    assign video.vblank  = state != mist_pkg::st_active;
    assign video.vs      = state == mist_pkg::st_sync;

    a_hs_in_hblank: assert property (
        @(posedge clk) disable iff (reset) video.hs |-> video.hblank
    ) else $error("video_timing: hs outside hblank");

    a_vs_in_vblank: assert property (
        @(posedge clk) disable iff (reset) video.vs |-> video.vblank
    ) else $error("video_timing: vs outside vblank");

endmodule

// ==== verilog/pixel_gen.sv ====
`timescale 1ns/1ns

module pixel_gen #(
    parameter int ROM_AW    = 10,
    parameter int H_VISIBLE = 16
) (
    input  logic              clk,
    input  logic              reset,
    video_if.sink             video,
    ioctl_if.monitor          ioctl,
    output logic [ROM_AW-1:0] rd_addr,
    input  mist_pkg::byte_t   rd_data,
    output logic              hs,
    output logic              vs,
    output logic              hblank,
    output logic              vblank,
    output mist_pkg::color_t  red,
    output mist_pkg::color_t  green,
    output mist_pkg::color_t  blue
);

    logic [31:0]      lin_addr;
    mist_pkg::color_t hi_nib;
    mist_pkg::color_t lo_nib;
    logic             blank;

    // linear image address, wraps at the ROM size
    assign lin_addr = 32'(video.vcnt) * H_VISIBLE + 32'(video.hcnt);
    assign rd_addr  = lin_addr[ROM_AW-1:0];

    assign hi_nib = rd_data[7:4];
    assign lo_nib = rd_data[3:0];
    assign blank  = video.hblank | video.vblank | ioctl.downloading;

    // rd_data is valid by the pxl_cen cycle since CEN_DIV >= 2
    always_ff @(posedge clk) begin
        if (reset) begin
            hs     <= 1'b0;
            vs     <= 1'b0;
            hblank <= 1'b0;
            vblank <= 1'b0;
            red    <= '0;
            green  <= '0;
            blue   <= '0;
        end else if (video.pxl_cen) begin
            hs     <= video.hs;
            vs     <= video.vs;
            hblank <= video.hblank;
            vblank <= video.vblank;
            red    <= blank ? '0 : hi_nib;
            green  <= blank ? '0 : lo_nib;
            blue   <= blank ? '0 : hi_nib ^ lo_nib;
        end
    end

    a_black_in_blank: assert property (
        @(posedge clk) disable iff (reset)
        (hblank || vblank) |-> (red == '0 && green == '0 && blue == '0)
    ) else $error("pixel_gen: colour during blanking");

endmodule

// ==== verilog/mist_top.sv ====
`timescale 1ns/1ns

module mist_top #(
    parameter int ROM_AW    = 10,
    parameter int H_VISIBLE = 16,
    parameter int H_TOTAL   = 24,
    parameter int V_VISIBLE = 8,
    parameter int V_TOTAL   = 12,
    parameter int CEN_DIV   = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             spi_sck,
    input  logic             spi_ss2,
    input  logic             spi_di,
    output logic             downloading,
    output logic             pxl_cen,
    output logic             hs,
    output logic             vs,
    output logic             hblank,
    output logic             vblank,
    output mist_pkg::color_t red,
    output mist_pkg::color_t green,
    output mist_pkg::color_t blue
);

    logic [ROM_AW-1:0] rd_addr;
    mist_pkg::byte_t   rd_data;

    ioctl_if #(.ROM_AW(ROM_AW)) ioctl ();

    video_if #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) video ();

    spi_download u_spi (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .spi_sck ( spi_sck ),
        .spi_ss2 ( spi_ss2 ),
        .spi_di  ( spi_di  ),
        .ioctl   ( ioctl   )
    );

    rom_buffer #(.ROM_AW(ROM_AW)) u_rom (
        .clk     ( clk     ),
        .ioctl   ( ioctl   ),
        .rd_addr ( rd_addr ),
        .rd_data ( rd_data )
    );

    video_timing #(
        .H_VISIBLE ( H_VISIBLE ),
        .H_TOTAL   ( H_TOTAL   ),
        .V_VISIBLE ( V_VISIBLE ),
        .V_TOTAL   ( V_TOTAL   ),
        .CEN_DIV   ( CEN_DIV   )
    ) u_timing (
        .clk   ( clk   ),
        .reset ( reset ),
        .video ( video )
    );

    pixel_gen #(
        .ROM_AW    ( ROM_AW    ),
        .H_VISIBLE ( H_VISIBLE )
    ) u_pixel (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .video   ( video   ),
        .ioctl   ( ioctl   ),
        .rd_addr ( rd_addr ),
        .rd_data ( rd_data ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .hblank  ( hblank  ),
        .vblank  ( vblank  ),
        .red     ( red     ),
        .green   ( green   ),
        .blue    ( blue    )
    );

    assign downloading = ioctl.downloading;
    assign pxl_cen     = video.pxl_cen;

endmodule

// ==== test/test_harness.sv ====
`timescale 1ns/1ns

module test_harness #(
    parameter int ROM_AW = 10
) (
    input  logic clk,
    output logic spi_sck,
    output logic spi_ss2,
    output logic spi_di
);

    localparam int DEPTH    = 1 << ROM_AW;
    // clocks per half SPI bit
    localparam int SPI_HALF = 4;

    logic [31:0] rng;
    // bytes the ROM should hold after each download
    logic [7:0]  mirror [0:DEPTH-1];

    initial begin
        rng     = 32'h81d0;
        spi_sck = 1'b0;
        spi_ss2 = 1'b1;
        spi_di  = 1'b0;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // data set up while sck is low, taken on the rising sck edge
    task automatic send_bit(input logic b);
        spi_sck = 1'b0;
        spi_di  = b;
        repeat (SPI_HALF) @(negedge clk);
        spi_sck = 1'b1;
        repeat (SPI_HALF) @(negedge clk);
        spi_sck = 1'b0;
    endtask

    // tail_bits of one more byte go out before ss2 rises and are never stored
    task automatic download(input int n_bytes, input int tail_bits);
        logic [7:0] b;
        @(negedge clk);
        spi_ss2 = 1'b0;
        repeat (SPI_HALF) @(negedge clk);
        for (int i = 0; i < n_bytes; i++) begin
            rng = xorshift(rng);
            b   = rng[7:0];
            for (int k = 7; k >= 0; k--) begin
                send_bit(b[k]);
            end
            mirror[i % DEPTH] = b;
        end
        if (tail_bits > 0) begin
            rng = xorshift(rng);
            b   = rng[7:0];
            for (int k = 7; k > 7 - tail_bits; k--) begin
                send_bit(b[k]);
            end
        end
        repeat (SPI_HALF) @(negedge clk);
        spi_ss2 = 1'b1;
        repeat (4 * SPI_HALF) @(negedge clk);
    endtask

endmodule

// ==== test/mist_test.sv ====
`timescale 1ns/1ns

module mist_test;

    localparam int ROM_AW     = 10;
    localparam int H_VISIBLE  = 16;
    localparam int H_TOTAL    = 24;
    localparam int V_VISIBLE  = 8;
    localparam int V_TOTAL    = 12;
    localparam int CEN_DIV    = 2;
    localparam int ROM_DEPTH  = 1 << ROM_AW;
    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * CEN_DIV;
    localparam int PART_BYTES = 37;
    localparam int PART_BITS  = 5;

    localparam int CAT_RESET    = 0;
    localparam int CAT_DOWNLOAD = 1;
    localparam int CAT_IMAGE    = 2;
    localparam int CAT_GEOMETRY = 3;
    localparam int CAT_TIMEOUT  = 4;

    logic             clk;
    logic             reset;
    logic             spi_sck;
    logic             spi_ss2;
    logic             spi_di;
    logic             downloading;
    logic             pxl_cen;
    logic             hs;
    logic             vs;
    logic             hblank;
    logic             vblank;
    mist_pkg::color_t red;
    mist_pkg::color_t green;
    mist_pkg::color_t blue;

    int   err_count [0:4];
    logic timed_out;
    int   ss_low_clks;
    int   ss_high_clks;
    logic dl_level;
    int   frame_cnt;
    int   image_frames_left;
    logic image_active;
    int   pixels_checked;
    // picture position and per-line, per-frame measurements
    logic prev_hblank;
    logic prev_vblank;
    logic prev_hs;
    logic prev_dl;
    logic h_synced;
    logic v_synced;
    int   hpos;
    int   vpos;
    int   line_samples;
    int   line_visible;
    int   hs_run;
    int   frame_lines;
    int   frame_vs_lines;
    // clocks between pixel enables
    int   cen_gap;
    logic cen_seen;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    mist_top #(
        .ROM_AW    ( ROM_AW    ),
        .H_VISIBLE ( H_VISIBLE ),
        .H_TOTAL   ( H_TOTAL   ),
        .V_VISIBLE ( V_VISIBLE ),
        .V_TOTAL   ( V_TOTAL   ),
        .CEN_DIV   ( CEN_DIV   )
    ) mist_top_i (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .spi_sck     ( spi_sck     ),
        .spi_ss2     ( spi_ss2     ),
        .spi_di      ( spi_di      ),
        .downloading ( downloading ),
        .pxl_cen     ( pxl_cen     ),
        .hs          ( hs          ),
        .vs          ( vs          ),
        .hblank      ( hblank      ),
        .vblank      ( vblank      ),
        .red         ( red         ),
        .green       ( green       ),
        .blue        ( blue        )
    );

    test_harness #(.ROM_AW(ROM_AW)) u_harness (
        .clk     ( clk     ),
        .spi_sck ( spi_sck ),
        .spi_ss2 ( spi_ss2 ),
        .spi_di  ( spi_di  )
    );

    task automatic check_equal(input string test, input int cat,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s: expected %0h, actual %0h", test, expected, actual);
            err_count[cat]++;
        end
    endtask

    task automatic check_quiet(input string test);
        check_equal({test, " flags"}, CAT_RESET, 0, {downloading, hs, vs});
        check_equal({test, " colour"}, CAT_RESET, 0, {red, green, blue});
    endtask

    // red is the high nibble, green the low one, blue their XOR
    function automatic logic [11:0] expected_color(input int h, input int v);
        logic [7:0] b;
        int         addr;
        addr = (v * H_VISIBLE + h) % ROM_DEPTH;
        b    = u_harness.mirror[addr];
        return {b[7:4], b[3:0], b[7:4] ^ b[3:0]};
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        err_count[CAT_TIMEOUT]++;
        timed_out = 1'b1;
    endtask

    task automatic wait_download_idle();
        int n;
        n = 0;
        while (dl_level && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (dl_level) report_timeout("downloading to drop after the download");
    endtask

    task automatic wait_frames(input int count);
        int target;
        int n;
        target = frame_cnt + count;
        n      = 0;
        while (frame_cnt < target && n < (count + 1) * FRAME_CLKS) begin
            @(posedge clk);
            n++;
        end
        if (frame_cnt < target) report_timeout("the next frame start");
    endtask

    task automatic run_tests();
        u_harness.download(ROM_DEPTH, 0);
        wait_download_idle();
        if (timed_out) return;
        image_frames_left = 2;
        wait_frames(3);
        if (timed_out) return;
        // cut off mid-byte so only the first bytes change
        u_harness.download(PART_BYTES, PART_BITS);
        wait_download_idle();
        if (timed_out) return;
        image_frames_left = 2;
        wait_frames(3);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            ss_low_clks  = 0;
            ss_high_clks = 0;
        end else if (spi_ss2) begin
            ss_high_clks++;
            ss_low_clks = 0;
        end else begin
            ss_low_clks++;
            ss_high_clks = 0;
        end
    end

    // sampled mid-cycle while pxl_cen is high
    always @(negedge clk) begin : compare_pixels
        logic        hfall;
        logic        vfall;
        logic [11:0] color;
        dl_level = downloading;
        if (reset) begin
            prev_hblank  = 1'b0;
            prev_vblank  = 1'b0;
            prev_hs      = 1'b0;
            prev_dl      = 1'b0;
            h_synced     = 1'b0;
            v_synced     = 1'b0;
            image_active = 1'b0;
            frame_cnt    = 0;
            hpos         = 0;
            vpos         = 0;
            hs_run       = 0;
            cen_gap      = 0;
            cen_seen     = 1'b0;
        end else begin
            if (ss_low_clks >= 4) check_equal("download level", CAT_DOWNLOAD, 1, downloading);
            if (ss_high_clks >= 4) check_equal("download idle", CAT_DOWNLOAD, 0, downloading);
            cen_gap++;
            if (pxl_cen) begin
                if (cen_seen) begin
                    check_equal("pixel enable period", CAT_GEOMETRY, CEN_DIV, cen_gap);
                end
                cen_seen = 1'b1;
                cen_gap  = 0;
                hfall = prev_hblank & ~hblank;
                vfall = prev_vblank & ~vblank;
                if (hfall) begin
                    if (h_synced) begin
                        check_equal("line samples", CAT_GEOMETRY, H_TOTAL, line_samples);
                        check_equal("line visible", CAT_GEOMETRY, H_VISIBLE, line_visible);
                    end
                    h_synced     = 1'b1;
                    line_samples = 0;
                    line_visible = 0;
                    hpos         = 0;
                    if (vfall) begin
                        if (v_synced) begin
                            check_equal("frame lines", CAT_GEOMETRY, V_TOTAL, frame_lines);
                            check_equal("vs lines", CAT_GEOMETRY, 2, frame_vs_lines);
                        end
                        v_synced       = 1'b1;
                        frame_lines    = 0;
                        frame_vs_lines = 0;
                        vpos           = 0;
                        frame_cnt++;
                        image_active = image_frames_left > 0;
                        if (image_frames_left > 0) image_frames_left--;
                    end else begin
                        vpos++;
                    end
                    frame_lines++;
                    if (vs) frame_vs_lines++;
                end else begin
                    hpos++;
                end
                line_samples++;
                if (!hblank) line_visible++;
                if (hs) begin
                    check_equal("hs in hblank", CAT_GEOMETRY, 1, hblank);
                    hs_run++;
                end else if (prev_hs) begin
                    check_equal("hs width", CAT_GEOMETRY, 4, hs_run);
                    hs_run = 0;
                end
                if (vs) check_equal("vs in vblank", CAT_GEOMETRY, 1, vblank);
                color = {red, green, blue};
                if (hblank || vblank) begin
                    check_equal("blank colour", CAT_IMAGE, 0, color);
                end else if (prev_dl && downloading) begin
                    check_equal("download colour", CAT_DOWNLOAD, 0, color);
                end else if (image_active && v_synced) begin
                    check_equal("image pixel", CAT_IMAGE, expected_color(hpos, vpos), color);
                    pixels_checked++;
                end
                prev_hblank = hblank;
                prev_vblank = vblank;
                prev_hs     = hs;
                prev_dl     = downloading;
            end
        end
    end

    initial begin : main_sequence
        int total;
        reset             = 1'b1;
        timed_out         = 1'b0;
        image_frames_left = 0;
        pixels_checked    = 0;
        for (int i = 0; i < 5; i++) begin
            err_count[i] = 0;
        end
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            check_quiet("reset");
        end
        reset = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_quiet("after reset");
        end
        run_tests();
        // two full frames after each download
        check_equal("image pixel count", CAT_IMAGE, 4 * H_VISIBLE * V_VISIBLE, pixels_checked);
        total = err_count[0] + err_count[1] + err_count[2] + err_count[3] + err_count[4];
        $display("errors: reset %0d, download %0d, image %0d, geometry %0d, timeout %0d",
                 err_count[CAT_RESET], err_count[CAT_DOWNLOAD], err_count[CAT_IMAGE],
                 err_count[CAT_GEOMETRY], err_count[CAT_TIMEOUT]);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
verilog/mist_pkg.sv
verilog/ioctl_if.sv
verilog/video_if.sv
verilog/spi_download.sv
verilog/rom_buffer.sv
verilog/video_timing.sv
verilog/pixel_gen.sv
verilog/mist_top.sv
test/test_harness.sv
test/mist_test.sv
